//--- verilog/offload_pkg.sv
// ################################################
// offload unit shared types
// opcodes, command and response records and
// queue depths used by the ALU offload datapath
// ################################################

`default_nettype none

package offload_pkg;

    // alu operations, encoded in 3 bits
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,  // a + b, wraps mod 2^16
        OP_SUB = 3'd1,  // a - b, wraps mod 2^16
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_SHL = 3'd4,  // a << b[3:0]
        OP_MIN = 3'd5   // unsigned minimum
    } alu_op_e;

    // command as pushed by the host (39 bits)
    typedef struct packed {
        logic [3:0]  tag;     // returned with the response
        alu_op_e     op;
        logic [15:0] a;
        logic [15:0] b;
    } cmd_t;

    // response as popped by the host (20 bits)
    typedef struct packed {
        logic [3:0]  tag;
        logic [15:0] result;
    } rsp_t;

    localparam int unsigned CMD_DEPTH = 4;  // command queue entries
    localparam int unsigned RSP_DEPTH = 4;  // response queue entries

    // occupancy count of the command queue, must reach CMD_DEPTH
    localparam int unsigned CMD_CNT_W = $clog2(CMD_DEPTH) + 1;

endpackage

`default_nettype wire

//--- verilog/fifo_queue.sv
// ################################################
// generic circular buffer FIFO
// type parameterized payload, occupancy count,
// synchronous flush and optional fall-through
// ################################################

`timescale 1ns/1ps
`default_nettype none

module fifo_queue #(
    parameter int unsigned DEPTH        = 4,           // number of entries, 2 or more
    parameter bit          FALL_THROUGH = 1'b0,        // empty queue passes data through
    parameter type         dtype        = logic [7:0]  // payload type
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,   // drops every entry at the edge
    input  dtype                   data_i,    // payload to push
    input  logic                   push_i,    // write strobe
    input  logic                   pop_i,     // advance the head
    output dtype                   data_o,    // current head
    output logic                   full_o,
    output logic                   empty_o,
    output logic [$clog2(DEPTH):0] usage_o    // number of stored entries
);

    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    // depth check at elaboration
    if (DEPTH < 2) begin : g_depth_check
        $error("fifo_queue needs DEPTH of at least 2");
    end

    // storage, written only on an accepted push
    dtype mem_q [DEPTH];

    logic [PTR_W-1:0] rd_ptr_q, rd_ptr_d;  // head position
    logic [PTR_W-1:0] wr_ptr_q, wr_ptr_d;  // next free slot
    logic [CNT_W-1:0] cnt_q, cnt_d;        // occupancy

    logic push_ok;   // push accepted this cycle
    logic pop_ok;    // pop accepted this cycle
    logic bypass;    // item goes straight from data_i to data_o
    logic mem_we;

    // pointer step with wrap at DEPTH
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // status flags
    assign full_o  = (cnt_q == CNT_W'(DEPTH));
    assign empty_o = (cnt_q == '0) & ~(FALL_THROUGH & push_i);  // push makes it non-empty early
    assign usage_o = cnt_q;

    assign push_ok = push_i & ~full_o;
    assign pop_ok  = pop_i & ~empty_o;
    assign bypass  = FALL_THROUGH & (cnt_q == '0) & push_i & pop_i;
    assign mem_we  = push_ok & ~bypass;  // bypassed item never lands in memory

    // head is the pushed word itself while an empty queue falls through
    assign data_o = (FALL_THROUGH && (cnt_q == '0)) ? data_i : mem_q[rd_ptr_q];

    always_comb begin
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;

        if (push_ok && !bypass) begin
            wr_ptr_d = ptr_inc(wr_ptr_q);
        end
        if (pop_ok && !bypass) begin
            rd_ptr_d = ptr_inc(rd_ptr_q);
        end

        // simultaneous push and pop keeps the count
        if (push_ok && !pop_ok) begin
            cnt_d = cnt_q + 1'b1;
        end else if (!push_ok && pop_ok) begin
            cnt_d = cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            // flush wins over any push or pop in the same cycle
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_we) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // producer must respect full
    a_no_push_full : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        full_o |-> !push_i
    ) else $error("push into a full FIFO");

    // consumer must respect empty
    a_no_pop_empty : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        empty_o |-> !pop_i
    ) else $error("pop from an empty FIFO");

endmodule

`default_nettype wire

//--- verilog/alu_stage.sv
// ################################################
// single stage ALU
// pops a command, computes the 16 bit result and
// holds tag and result until the response queue
// takes them
// ################################################

`timescale 1ns/1ps
`default_nettype none

module alu_stage (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,      // drops the held result
    input  offload_pkg::cmd_t   cmd_i,        // head of the command queue
    input  logic                cmd_empty_i,
    output logic                cmd_pop_o,    // one strobe per command taken
    output offload_pkg::rsp_t   rsp_o,        // registered response
    output logic                rsp_push_o,   // offered only while the queue has room
    input  logic                rsp_full_i    // response queue back-pressure
);

    import offload_pkg::*;

    rsp_t rsp_d;        // combinational result for the head command
    rsp_t rsp_q;        // output register payload
    logic rsp_valid_q;  // output register holds an item
    logic rsp_taken;    // response queue accepts the item this cycle

    assign rsp_taken = rsp_valid_q & ~rsp_full_i;

    // take a new command when the register is free or draining now
    assign cmd_pop_o = ~cmd_empty_i & (~rsp_valid_q | rsp_taken);

    // opcode decode and datapath
    always_comb begin
        rsp_d.tag = cmd_i.tag;
        case (cmd_i.op)
            OP_ADD:  rsp_d.result = cmd_i.a + cmd_i.b;   // wraps
            OP_SUB:  rsp_d.result = cmd_i.a - cmd_i.b;   // wraps
            OP_AND:  rsp_d.result = cmd_i.a & cmd_i.b;
            OP_XOR:  rsp_d.result = cmd_i.a ^ cmd_i.b;
            OP_SHL:  rsp_d.result = cmd_i.a << cmd_i.b[3:0];
            OP_MIN:  rsp_d.result = (cmd_i.a < cmd_i.b) ? cmd_i.a : cmd_i.b;
            default: rsp_d.result = '0;  // unused encodings
        endcase
    end

    // valid flag
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
        end else if (flush_i) begin
            rsp_valid_q <= 1'b0;
        end else if (cmd_pop_o) begin
            rsp_valid_q <= 1'b1;  // refill, possibly while draining
        end else if (rsp_taken) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // payload, loaded only on a pop
    always_ff @(posedge clk_i) begin
        if (cmd_pop_o) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_o      = rsp_q;
    assign rsp_push_o = rsp_taken;  // held item waits out a full queue

    // a stalled response stays put until the queue takes it
    a_hold_stalled : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (rsp_valid_q && rsp_full_i && !flush_i) |=> (rsp_valid_q && $stable(rsp_q))
    ) else $error("ALU result changed while stalled");

endmodule

`default_nettype wire

//--- verilog/offload_unit.sv
// ################################################
// arithmetic offload unit top level
// command queue, ALU stage and response queue in
// a chain that keeps command order
// ################################################

`timescale 1ns/1ps
`default_nettype none

module offload_unit (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,      // clears queues and ALU register
    // host command side
    input  offload_pkg::cmd_t                 cmd_i,
    input  logic                              cmd_push_i,
    output logic                              cmd_full_o,
    output logic [offload_pkg::CMD_CNT_W-1:0] cmd_usage_o,  // command queue occupancy
    // host response side
    output offload_pkg::rsp_t                 rsp_o,        // head of the response queue
    output logic                              rsp_empty_o,
    input  logic                              rsp_pop_i
);

    import offload_pkg::*;

    // command queue to ALU
    cmd_t cmd_head;
    logic cmd_empty;
    logic cmd_pop;

    // ALU to response queue
    rsp_t alu_rsp;
    logic alu_push;
    logic rsp_full;

    // fall-through so a command reaches the ALU in its push cycle
    fifo_queue #(
        .DEPTH        (CMD_DEPTH),
        .FALL_THROUGH (1'b1),
        .dtype        (cmd_t)
    ) cmd_queue_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .data_i  (cmd_i),
        .push_i  (cmd_push_i),
        .pop_i   (cmd_pop),
        .data_o  (cmd_head),
        .full_o  (cmd_full_o),
        .empty_o (cmd_empty),
        .usage_o (cmd_usage_o)
    );

    alu_stage alu_stage_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .cmd_i       (cmd_head),
        .cmd_empty_i (cmd_empty),
        .cmd_pop_o   (cmd_pop),
        .rsp_o       (alu_rsp),
        .rsp_push_o  (alu_push),
        .rsp_full_i  (rsp_full)
    );

    // registered output, no fall-through
    fifo_queue #(
        .DEPTH        (RSP_DEPTH),
        .FALL_THROUGH (1'b0),
        .dtype        (rsp_t)
    ) rsp_queue_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .data_i  (alu_rsp),
        .push_i  (alu_push),
        .pop_i   (rsp_pop_i),
        .data_o  (rsp_o),
        .full_o  (rsp_full),
        .empty_o (rsp_empty_o),
        .usage_o ()             // host sees only empty
    );

endmodule

`default_nettype wire

//--- verif/offload_unit_tb.sv
// ################################################
// offload unit testbench
// table driven commands with random push and pop,
// back-pressure, flush and in-order response check
// ################################################

`timescale 1ns/1ps
`default_nettype none

module offload_unit_tb;

    import offload_pkg::*;

    localparam int TBL_N           = 16;
    localparam int HOLD            = RSP_DEPTH + 1;              // items the stage takes, then stalls
    localparam int CHAIN_CAP       = CMD_DEPTH + 1 + RSP_DEPTH;  // commands the chain can hold
    localparam int WATCHDOG_CYCLES = 40 * TBL_N + 200;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                 clk;
    logic                 rst_n;
    logic                 flush;
    cmd_t                 cmd;
    logic                 cmd_push;
    logic                 cmd_full;
    logic [CMD_CNT_W-1:0] cmd_usage;
    rsp_t                 rsp;
    logic                 rsp_empty;
    logic                 rsp_pop;

    cmd_t        tbl_cmd[$];  // command table
    logic [15:0] tbl_res[$];  // expected result per entry, worked out by hand
    logic [31:0] lfsr;
    int          tx;          // next table entry to push
    int          rx;          // next table entry expected back
    logic        push_bit;
    logic        pop_bit;

    offload_unit dut_i (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .flush_i     (flush),
        .cmd_i       (cmd),
        .cmd_push_i  (cmd_push),
        .cmd_full_o  (cmd_full),
        .cmd_usage_o (cmd_usage),
        .rsp_o       (rsp),
        .rsp_empty_o (rsp_empty),
        .rsp_pop_i   (rsp_pop)
    );

    always #4 clk = ~clk;  // 8 ns period

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp));
        end
    endtask

    // head of the response queue against table entry idx
    task automatic compare_head(input int idx);
        check_value(32'(rsp.tag), 32'(tbl_cmd[idx].tag), $sformatf("entry %0d tag", idx));
        check_value(32'(rsp.result), 32'(tbl_res[idx]), $sformatf("entry %0d result", idx));
    endtask

    // galois form, shifts right, one step per bit taken
    function automatic logic take_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        return b;
    endfunction

    task automatic add_entry(input logic [3:0] tag, input alu_op_e op, input logic [15:0] a,
                             input logic [15:0] b, input logic [15:0] res);
        cmd_t c;
        c.tag = tag;
        c.op  = op;
        c.a   = a;
        c.b   = b;
        tbl_cmd.push_back(c);
        tbl_res.push_back(res);
    endtask

    task automatic fill_table();
        add_entry(4'h0, OP_ADD, 16'h1234, 16'h1111, 16'h2345);
        add_entry(4'h1, OP_ADD, 16'hffff, 16'h0003, 16'h0002);  // wraps
        add_entry(4'h2, OP_SUB, 16'h5000, 16'h1000, 16'h4000);
        add_entry(4'h3, OP_SUB, 16'h0001, 16'h0002, 16'hffff);  // borrow wraps
        add_entry(4'h4, OP_AND, 16'hf0f0, 16'h3c3c, 16'h3030);
        add_entry(4'h5, OP_XOR, 16'haaaa, 16'hffff, 16'h5555);
        add_entry(4'h6, OP_SHL, 16'h0001, 16'h000f, 16'h8000);
        add_entry(4'h7, OP_SHL, 16'h00ff, 16'h0014, 16'h0ff0);  // only b[3:0] counts
        add_entry(4'h8, OP_MIN, 16'h1234, 16'h8000, 16'h1234);
        add_entry(4'h9, OP_MIN, 16'hfffe, 16'h7fff, 16'h7fff);  // unsigned compare
        add_entry(4'ha, OP_ADD, 16'h8000, 16'h8000, 16'h0000);
        add_entry(4'hb, OP_XOR, 16'h1357, 16'h1357, 16'h0000);
        add_entry(4'hc, OP_AND, 16'hffff, 16'h00ff, 16'h00ff);
        add_entry(4'hd, OP_SUB, 16'h0000, 16'h8000, 16'h8000);
        add_entry(4'he, OP_SHL, 16'habcd, 16'h0004, 16'hbcd0);
        add_entry(4'hf, OP_MIN, 16'h0005, 16'h0005, 16'h0005);
    endtask

    // whole table, push and pop moments picked by the lfsr
    task automatic random_traffic();
        tx = 0;
        rx = 0;
        while (rx < TBL_N) begin
            @(negedge clk);
            push_bit = take_bit();
            pop_bit  = take_bit();
            cmd_push = 1'b0;
            rsp_pop  = 1'b0;
            if (push_bit && tx < TBL_N && !cmd_full) begin
                cmd      = tbl_cmd[tx];
                cmd_push = 1'b1;
                tx++;
            end
            if (pop_bit && !rsp_empty) begin
                compare_head(rx);
                rsp_pop = 1'b1;
                rx++;
            end
        end
        @(negedge clk);
        cmd_push = 1'b0;
        rsp_pop  = 1'b0;
    endtask

    // no pops, fill until full, then drain
    task automatic fill_then_drain();
        int pushes;
        pushes = 0;
        while (!cmd_full && pushes < TBL_N) begin
            check_value(32'(cmd_usage), 32'((pushes > HOLD) ? (pushes - HOLD) : 0),
                        "cmd_usage under back-pressure");
            cmd      = tbl_cmd[pushes];
            cmd_push = 1'b1;
            pushes++;
            @(negedge clk);
        end
        cmd_push = 1'b0;
        check_value(32'(pushes), 32'(CHAIN_CAP), "pushes accepted before cmd_full");
        check_value(32'(cmd_usage), 32'(CMD_DEPTH), "cmd_usage while full");
        rx = 0;
        while (rx < CHAIN_CAP) begin
            rsp_pop = 1'b0;
            if (!rsp_empty) begin
                compare_head(rx);
                rsp_pop = 1'b1;
                rx++;
            end
            @(negedge clk);
        end
        rsp_pop = 1'b0;
        check_value(32'(rsp_empty), 32'd1, "rsp_empty after drain");
    endtask

    task automatic flush_in_flight();
        for (int i = 0; i < 6; i++) begin
            cmd      = tbl_cmd[10 + i];
            cmd_push = 1'b1;
            @(negedge clk);
        end
        cmd_push = 1'b0;
        check_value(32'(rsp_empty), 32'd0, "rsp_empty with items in flight");
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_value(32'(rsp_empty), 32'd1, "rsp_empty after flush");
        check_value(32'(cmd_usage), 32'd0, "cmd_usage after flush");
        @(negedge clk);
        check_value(32'(rsp_empty), 32'd1, "rsp_empty a cycle after flush");  // stage reg gone too
        cmd      = tbl_cmd[7];
        cmd_push = 1'b1;
        @(negedge clk);
        cmd_push = 1'b0;
        while (rsp_empty) begin
            @(negedge clk);
        end
        compare_head(7);
        rsp_pop = 1'b1;
        @(negedge clk);
        rsp_pop = 1'b0;
        check_value(32'(rsp_empty), 32'd1, "rsp_empty after last pop");
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        flush    = 1'b0;
        cmd      = '0;
        cmd_push = 1'b0;
        rsp_pop  = 1'b0;
        lfsr     = 32'h42a7;
        fill_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value(32'(rsp_empty), 32'd1, "rsp_empty after reset");
        check_value(32'(cmd_full), 32'd0, "cmd_full after reset");
        check_value(32'(cmd_usage), 32'd0, "cmd_usage after reset");
        random_traffic();
        fill_then_drain();
        flush_in_flight();
        $display("RESULT: PASS");
        $finish;
    end

    // ends a hung run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run($sformatf("watchdog: the run timed out after %0d cycles", WATCHDOG_CYCLES));
    end

endmodule

`default_nettype wire

//--- offload_unit.f
verilog/offload_pkg.sv
verilog/fifo_queue.sv
verilog/alu_stage.sv
verilog/offload_unit.sv
verif/offload_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the offload unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module offload_unit_tb -f offload_unit.f \
    -Mdir obj_dir -o offload_unit_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/offload_unit_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0
